// ==== irq_vector_fetch.f ====
source/irq_fetch_pkg.sv
source/ldst_if.sv
source/irq_dispatch.sv
source/handler_read.sv
source/ldst_arbiter.sv
source/irq_vector_fetch.sv
verif/tb_irq_vector_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_irq_vector_fetch \
	-f irq_vector_fetch.f -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log && { echo "PASS"; exit 0; } \
	|| { echo "FAIL: no result in log"; exit 1; }

// ==== source/handler_read.sv ====
`timescale 1ns/100ps

module handler_read import irq_fetch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input addr_t idt_base,
	input logic start,
	input irq_num_t start_irq,
	output logic finish,
	output word_t handler,
	ldst_if.requester ldst
);

	read_state_t state;
	logic read_req;
	addr_t read_addr;
	addr_t entry_addr;
	logic taken;
	logic load_done;

	// base + 8 * irq + 4
	assign entry_addr = idt_base
		+ (addr_t'(start_irq) << IDT_ENTRY_SHIFT)
		+ addr_t'(IDT_HANDLER_OFFSET);

	assign taken = read_req && !ldst.busy;
	assign load_done = (state == RD_LOAD) && ldst.ack;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= RD_IDLE;
			read_req <= 1'b0;
			finish <= 1'b0;
		end else if (reset_sync) begin
			state <= RD_IDLE;
			read_req <= 1'b0;
			finish <= 1'b0;
		end else begin
			finish <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (start) begin
						state <= RD_LOAD;
						read_req <= 1'b1;
					end
				end
				RD_LOAD: begin
					if (taken) begin
						read_req <= 1'b0;	// Arbiter took it
					end
					if (ldst.ack) begin
						state <= RD_IDLE;
						finish <= 1'b1;
					end
				end
			endcase
		end
	end

	// IRQ can be replaced in the dispatcher slot once started,
	// so the entry address is captured here
	always_ff @(posedge iCLOCK) begin
		if (state == RD_IDLE && start) begin
			read_addr <= entry_addr;
		end
		if (load_done && !reset_sync) begin
			handler <= ldst.data;	// Valid until next finish
		end
	end

	assign ldst.in_use = (state == RD_LOAD);
	assign ldst.req = read_req;
	assign ldst.addr = read_addr;

endmodule

// ==== source/irq_dispatch.sv ====
`timescale 1ns/100ps

module irq_dispatch import irq_fetch_pkg::*; #(
	parameter int NUM_CHANNELS = 4,
	localparam int CH_W = chan_sel_width(NUM_CHANNELS)
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic irq_valid,
	input irq_num_t irq_num,
	input logic [CH_W-1:0] irq_channel,
	input logic [NUM_CHANNELS-1:0] finish,
	output logic [NUM_CHANNELS-1:0] start,
	output irq_num_t [NUM_CHANNELS-1:0] start_irq,
	output logic irq_drop
);

	logic [NUM_CHANNELS-1:0] pending;	// One slot per channel
	logic [NUM_CHANNELS-1:0] running;
	irq_num_t [NUM_CHANNELS-1:0] slot_irq;
	logic in_range;
	logic accept;

	assign in_range = (int'(irq_channel) < NUM_CHANNELS);

	// Out of range channel counts as a drop
	assign accept = irq_valid && in_range && !pending[irq_channel];

	assign start = pending & ~running;
	assign start_irq = slot_irq;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending <= '0;
			running <= '0;
			irq_drop <= 1'b0;
		end else if (reset_sync) begin
			pending <= '0;
			running <= '0;
			irq_drop <= 1'b0;
		end else begin
			irq_drop <= irq_valid && !accept;
			for (int i = 0; i < NUM_CHANNELS; i++) begin
				if (start[i]) begin
					pending[i] <= 1'b0;
					running[i] <= 1'b1;
				end else if (finish[i]) begin
					running[i] <= 1'b0;	// Channel idle again
				end
			end
			if (accept) begin
				pending[irq_channel] <= 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			slot_irq[irq_channel] <= irq_num;
		end
	end

endmodule

// ==== source/irq_fetch_pkg.sv ====
package irq_fetch_pkg;

	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;
	localparam int IRQ_W = 7;

	typedef logic [ADDR_W-1:0] addr_t;	// Byte address
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [IRQ_W-1:0] irq_num_t;

	typedef enum logic {
		RD_IDLE,
		RD_LOAD
	} read_state_t;

	// IDT entry is eight bytes
	localparam int IDT_ENTRY_SHIFT = 3;
	// Handler word sits in the upper half of the entry
	localparam int IDT_HANDLER_OFFSET = 4;

	// Width of a channel index, never below one bit
	function automatic int chan_sel_width(int n);
		int w;
		w = (n > 1) ? $clog2(n) : 1;
		return w;
	endfunction

endpackage

// ==== source/irq_vector_fetch.sv ====
`timescale 1ns/100ps

module irq_vector_fetch import irq_fetch_pkg::*; #(
	parameter int NUM_CHANNELS = 4,
	localparam int CH_W = chan_sel_width(NUM_CHANNELS)
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input addr_t idt_base,
	input logic irq_valid,
	input irq_num_t irq_num,
	input logic [CH_W-1:0] irq_channel,
	output logic irq_drop,
	output logic [NUM_CHANNELS-1:0] handler_valid,
	output word_t [NUM_CHANNELS-1:0] handler_addr,
	output logic mem_req,
	output addr_t mem_addr,
	input logic mem_busy,
	input logic mem_ack,
	input word_t mem_data
);

	logic [NUM_CHANNELS-1:0] start;
	irq_num_t [NUM_CHANNELS-1:0] start_irq;

	ldst_if ldst [NUM_CHANNELS] ();

	irq_dispatch #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_dispatch (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.irq_valid(irq_valid),
		.irq_num(irq_num),
		.irq_channel(irq_channel),
		.finish(handler_valid),	// Finish frees the channel
		.start(start),
		.start_irq(start_irq),
		.irq_drop(irq_drop)
	);

	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_reader
		handler_read u_reader (
			.iCLOCK(iCLOCK),
			.inRESET(inRESET),
			.reset_sync(reset_sync),
			.idt_base(idt_base),
			.start(start[i]),
			.start_irq(start_irq[i]),
			.finish(handler_valid[i]),
			.handler(handler_addr[i]),
			.ldst(ldst[i])
		);
	end

	ldst_arbiter #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_arbiter (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.ch(ldst),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_busy(mem_busy),
		.mem_ack(mem_ack),
		.mem_data(mem_data)
	);

endmodule

// ==== source/ldst_arbiter.sv ====
`timescale 1ns/100ps

module ldst_arbiter import irq_fetch_pkg::*; #(
	parameter int NUM_CHANNELS = 4,
	localparam int CH_W = chan_sel_width(NUM_CHANNELS)
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	ldst_if.arbiter ch [NUM_CHANNELS],
	output logic mem_req,
	output addr_t mem_addr,
	input logic mem_busy,
	input logic mem_ack,
	input word_t mem_data
);

	logic [NUM_CHANNELS-1:0] ch_use;
	logic [NUM_CHANNELS-1:0] ch_req;
	addr_t [NUM_CHANNELS-1:0] ch_addr;
	logic granted;
	logic [CH_W-1:0] grant_idx;	// Also last winner for round robin
	logic hold;
	logic pick_valid;
	logic [CH_W-1:0] pick_idx;

	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_ch
		logic own;
		assign own = granted && (grant_idx == CH_W'(i));
		assign ch_use[i] = ch[i].in_use;
		assign ch_req[i] = ch[i].req;
		assign ch_addr[i] = ch[i].addr;
		assign ch[i].busy = !(own && !mem_busy);
		assign ch[i].ack = own && mem_ack;
		assign ch[i].data = mem_data;
	end

	assign hold = granted && ch_use[grant_idx];

	// Search starts one past the last winner
	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick_idx = grant_idx;
		for (int k = 1; k <= NUM_CHANNELS; k++) begin
			idx = (int'(grant_idx) + k) % NUM_CHANNELS;
			if (!pick_valid && ch_use[idx]) begin
				pick_valid = 1'b1;
				pick_idx = CH_W'(idx);
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			granted <= 1'b0;
			grant_idx <= '0;
		end else if (reset_sync) begin
			granted <= 1'b0;
			grant_idx <= '0;
		end else if (!hold) begin
			granted <= pick_valid;	// Free or released this cycle
			if (pick_valid) begin
				grant_idx <= pick_idx;
			end
		end
	end

	assign mem_req = granted && ch_req[grant_idx];
	assign mem_addr = ch_addr[grant_idx];

endmodule

// ==== source/ldst_if.sv ====
`timescale 1ns/100ps

// One channel's read path towards the shared load/store port
interface ldst_if import irq_fetch_pkg::*; ();

	logic in_use;	// Channel owns or wants the port
	logic req;
	addr_t addr;
	logic busy;
	logic ack;	// Data valid, single cycle
	word_t data;

	modport requester (
		output in_use,
		output req,
		output addr,
		input busy,
		input ack,
		input data
	);

	modport arbiter (
		input in_use,
		input req,
		input addr,
		output busy,
		output ack,
		output data
	);

endinterface

// ==== verif/tb_irq_vector_fetch.sv ====
`timescale 1ns/100ps

module tb_irq_vector_fetch;

	localparam int NCH = 4;
	localparam int MAX_DELAY = 4;	// Worst take-to-ack distance in cycles
	localparam int NUM_ROWS = 11;
	localparam int ROW_BOUND = 16 * (MAX_DELAY + 6);
	localparam int CYCLE_LIMIT = (NUM_ROWS + 1) * ROW_BOUND;
	localparam logic [31:0] IDT_BASE = 32'h0001_2000;
	localparam logic [31:0] MEM_KEY = 32'h5a3c_96e1;

	typedef enum int {K_SINGLE, K_ALL, K_DROP, K_QUEUE, K_RESET} kind_t;

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic reset_sync;
	logic [31:0] idt_base;
	logic irq_valid;
	logic [6:0] irq_num;
	logic [1:0] irq_channel;
	logic irq_drop;
	logic [NCH-1:0] handler_valid;
	logic [NCH-1:0][31:0] handler_addr;
	logic mem_req;
	logic [31:0] mem_addr;
	logic mem_busy = 1'b0;
	logic mem_ack = 1'b0;
	logic [31:0] mem_data = '0;

	integer seed = 70591;
	logic busy_on;
	logic busy_q = 1'b0;
	logic outstanding = 1'b0;
	logic [31:0] lat_addr = '0;
	int delay_cnt = 0;
	int cycles = 0;
	int err_cnt = 0;
	int drop_hits;
	int fin_cnt [NCH];
	logic [31:0] fin_word [NCH][2];	// First two handlers per channel

	string row_name [NUM_ROWS];
	kind_t row_kind [NUM_ROWS];
	int row_ch [NUM_ROWS];
	int row_irq [NUM_ROWS];
	int row_irq2 [NUM_ROWS];
	int row_drop [NUM_ROWS];
	logic row_busy [NUM_ROWS];

	irq_vector_fetch #(.NUM_CHANNELS(NCH)) dut0 (.*);

	always #4 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		busy_q <= busy_on;
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	// Memory model, one read in flight
	always @(negedge iCLOCK) begin
		mem_ack = 1'b0;
		mem_busy = busy_q && (($random(seed) & 1) == 1);
		if (outstanding) begin
			if (delay_cnt == 0) begin
				mem_ack = 1'b1;
				mem_data = lat_addr ^ MEM_KEY;
				outstanding = 1'b0;
			end else begin
				delay_cnt = delay_cnt - 1;
			end
		end else if (mem_req && !mem_busy) begin
			outstanding = 1'b1;	// Taken at the next rising edge
			lat_addr = mem_addr;
			delay_cnt = {$random(seed)} % MAX_DELAY;
		end
	end

	// Entry at base + 8 * irq + 4, then the memory data rule
	function automatic logic [31:0] expected_handler(input logic [6:0] irq);
		return (IDT_BASE + {22'd0, irq, 3'd0} + 32'd4) ^ MEM_KEY;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic next_cycle();
		@(negedge iCLOCK);
		if (irq_drop) drop_hits++;
		for (int c = 0; c < NCH; c++) begin
			if (handler_valid[c]) begin
				if (fin_cnt[c] < 2) fin_word[c][fin_cnt[c]] = handler_addr[c];
				fin_cnt[c]++;
			end
		end
	endtask

	task automatic drive_irq(input int ch, input logic [6:0] irq);
		next_cycle();
		irq_valid = 1'b1;
		irq_channel = 2'(ch);
		irq_num = irq;
	endtask

	task automatic idle_input();
		next_cycle();
		irq_valid = 1'b0;
	endtask

	task automatic wait_done(input int ch, input int count);
		while (fin_cnt[ch] < count) next_cycle();
	endtask

	task automatic set_row(input int r, input string name, input kind_t kind, input int ch,
			input int irq, input int irq2, input int drop, input int busy);
		row_name[r] = name;
		row_kind[r] = kind;
		row_ch[r] = ch;
		row_irq[r] = irq;
		row_irq2[r] = irq2;
		row_drop[r] = drop;
		row_busy[r] = (busy != 0);
	endtask

	task automatic run_row(input int r);
		int err_before;
		int ch;
		logic [6:0] irq;
		logic [6:0] irq2;
		err_before = err_cnt;
		ch = row_ch[r];
		irq = 7'(row_irq[r]);
		irq2 = 7'(row_irq2[r]);
		busy_on = row_busy[r];
		drop_hits = 0;
		for (int c = 0; c < NCH; c++) fin_cnt[c] = 0;
		case (row_kind[r])
			K_ALL: begin
				for (int c = 0; c < NCH; c++) drive_irq(c, irq + 7'(c));
				idle_input();
				for (int c = 0; c < NCH; c++) wait_done(c, 1);
				for (int c = 0; c < NCH; c++) begin
					check_value(row_name[r], expected_handler(irq + 7'(c)), fin_word[c][0]);
				end
			end
			K_DROP: begin
				drive_irq(ch, irq);
				drive_irq(ch, irq2);	// Slot still full here
				idle_input();
				wait_done(ch, 1);
				check_value(row_name[r], expected_handler(irq), fin_word[ch][0]);
			end
			K_QUEUE: begin
				drive_irq(ch, irq);
				idle_input();
				drive_irq(ch, irq2);
				idle_input();
				wait_done(ch, 2);
				check_value(row_name[r], expected_handler(irq), fin_word[ch][0]);
				check_value(row_name[r], expected_handler(irq2), fin_word[ch][1]);
			end
			K_RESET: begin
				drive_irq(ch, irq);
				idle_input();
				while (!mem_req) next_cycle();
				reset_sync = 1'b1;
				next_cycle();
				reset_sync = 1'b0;
				repeat (2 * MAX_DELAY + 4) next_cycle();
				if (fin_cnt[ch] != 0) begin
					$display("channel %0d returned a handler after reset_sync", ch);
					err_cnt++;
				end
				drive_irq(ch, irq2);
				idle_input();
				wait_done(ch, 1);
				check_value(row_name[r], expected_handler(irq2), fin_word[ch][0]);
			end
			default: begin
				drive_irq(ch, irq);
				idle_input();
				wait_done(ch, 1);
				check_value(row_name[r], expected_handler(irq), fin_word[ch][0]);
			end
		endcase
		check_value({row_name[r], " drop"}, 32'(row_drop[r]), 32'(drop_hits));
		repeat (2) next_cycle();
		$display("test %0d %s: %0d errors", r, row_name[r], err_cnt - err_before);
	endtask

	initial begin
		inRESET = 1'b0;
		reset_sync = 1'b0;
		idt_base = IDT_BASE;
		irq_valid = 1'b0;
		irq_num = '0;
		irq_channel = '0;
		busy_on = 1'b0;
		set_row(0, "single_ch0", K_SINGLE, 0, 5, 0, 0, 0);
		set_row(1, "single_ch1", K_SINGLE, 1, 17, 0, 0, 0);
		set_row(2, "single_ch2", K_SINGLE, 2, 64, 0, 0, 0);
		set_row(3, "single_ch3", K_SINGLE, 3, 127, 0, 0, 0);
		set_row(4, "all_channels", K_ALL, 0, 10, 0, 0, 0);
		set_row(5, "drop_full_slot", K_DROP, 2, 33, 34, 1, 0);
		set_row(6, "queued_request", K_QUEUE, 1, 40, 41, 0, 0);
		set_row(7, "busy_single", K_SINGLE, 3, 99, 0, 0, 1);
		set_row(8, "busy_all", K_ALL, 0, 100, 0, 0, 1);
		set_row(9, "busy_queued", K_QUEUE, 0, 2, 3, 0, 1);
		set_row(10, "soft_reset", K_RESET, 2, 70, 71, 0, 0);
		repeat (4) @(negedge iCLOCK);
		inRESET = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("tests %0d, errors %0d", NUM_ROWS, err_cnt);
		if (err_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
